// ==== verilog.f ====
+incdir+include
logic/jacobian_pkg.sv
logic/link_term_if.sv
logic/angle_accumulator.sv
logic/link_term.sv
logic/jacobian_assembler.sv
logic/planar_jacobian_top.sv
tests/planar_jacobian_sva.sv
tests/planar_jacobian_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log for the pass line.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
	-f verilog.f \
	--top-module planar_jacobian_tb \
	-o planar_jacobian_sim

./obj_dir/planar_jacobian_sim | tee sim.log

if grep -qx "all tests passed" sim.log; then
	echo "Simulation passed."
else
	echo "Simulation failed."
	exit 1
fi

// ==== tests/planar_jacobian_tb.sv ====
/* Self-checking testbench for planar_jacobian_top. Drives random and corner stimulus,
   checks every result against a floating-point model and prints a per-test summary. */
`timescale 1ns/1ns

module planar_jacobian_tb;

	localparam int NUM_LINKS = 4;
	localparam int LATENCY = 4; // Edges from a sampled start to done.
	localparam int N_ZERO = 8;
	localparam int N_ISOLATED = 200;
	localparam int MAX_GAP = 11;
	localparam int N_BURST = 200;
	localparam int N_CORNER = 72;
	localparam int NUM_TESTS = 5;
	localparam int WATCHDOG_CYCLES = N_ZERO + N_ISOLATED * (MAX_GAP + 1) + N_BURST
		+ N_CORNER + 20 * NUM_TESTS;
	localparam logic [31:0] SEED = 32'h392276e2;
	localparam real PI = 3.14159265358979;

	typedef jacobian_pkg::angle_t [NUM_LINKS-1:0] angle_vec_t;
	typedef jacobian_pkg::length_t [NUM_LINKS-1:0] length_vec_t;
	typedef jacobian_pkg::jac_t [NUM_LINKS-1:0] jac_vec_t;

	logic clk = 1'b0;
	logic rst_n;
	logic start;
	angle_vec_t joint_angles;
	length_vec_t link_lengths;
	logic done;
	jac_vec_t jac_x;
	jac_vec_t jac_y;

	int edge_count = 0;
	int error_count = 0;
	int pass_count = 0;
	int fail_count = 0;
	int in_flight = 0; // Starts taken minus results seen on done.
	int max_depth = 0; // Most results ever in flight at once.
	int due_q [$]; // Edge on which each pending result is due.
	jac_vec_t exp_x_q [$];
	jac_vec_t exp_y_q [$];
	jacobian_pkg::angle_t corners [8] = '{8'd0, 8'd63, 8'd64, 8'd127, 8'd128, 8'd191,
		8'd192, 8'd255};

	planar_jacobian_top #(
		.NUM_LINKS(NUM_LINKS)
	) u_dut (
		.clk(clk),
		.rst_n(rst_n),
		.start(start),
		.joint_angles(joint_angles),
		.link_lengths(link_lengths),
		.done(done),
		.jac_x(jac_x),
		.jac_y(jac_y)
	);

	initial begin
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		edge_count <= edge_count + 1;
	end

	// Sine sample scaled by 127, rounded half away from zero.
	function automatic int sample_sin(input int a);
		real v;
		v = 127.0 * $sin(2.0 * PI * real'(a) / 256.0);
		if (v >= 0.0) begin
			return $rtoi(v + 0.5);
		end
		return -$rtoi(0.5 - v);
	endfunction

	task automatic compute_expected(input angle_vec_t angles, input length_vec_t lengths,
		output jac_vec_t jx, output jac_vec_t jy);
		int phi;
		int sx;
		int sy;
		int xt [NUM_LINKS];
		int yt [NUM_LINKS];
		phi = 0;
		for (int i = 0; i < NUM_LINKS; i++) begin
			phi = (phi + int'(angles[i])) % 256; // Absolute link angle.
			xt[i] = int'(lengths[i]) * sample_sin((phi + 64) % 256);
			yt[i] = int'(lengths[i]) * sample_sin(phi);
		end
		sx = 0;
		sy = 0;
		for (int i = NUM_LINKS - 1; i >= 0; i--) begin
			sx += xt[i];
			sy += yt[i];
			jx[i] = jacobian_pkg::jac_t'(-sy);
			jy[i] = jacobian_pkg::jac_t'(sx);
		end
	endtask

	task automatic compare_results(input jac_vec_t exp_x, input jac_vec_t exp_y);
		for (int i = 0; i < NUM_LINKS; i++) begin
			if (jac_x[i] !== exp_x[i]) begin
				$display("[ERROR] %0t ns jac_x[%0d] expected %0d actual %0d", $time, i,
					$signed(exp_x[i]), $signed(jac_x[i]));
				error_count++;
			end
			if (jac_y[i] !== exp_y[i]) begin
				$display("[ERROR] %0t ns jac_y[%0d] expected %0d actual %0d", $time, i,
					$signed(exp_y[i]), $signed(jac_y[i]));
				error_count++;
			end
		end
	endtask

	// Outputs and inputs are both stable at the falling edge.
	always @(negedge clk) begin
		jac_vec_t jx;
		jac_vec_t jy;
		if (due_q.size() != 0 && due_q[0] == edge_count) begin
			if (done !== 1'b1) begin
				$display("%0t ns: a result was due but done stayed low", $time);
				error_count++;
			end else begin
				compare_results(exp_x_q[0], exp_y_q[0]);
			end
			void'(due_q.pop_front());
			void'(exp_x_q.pop_front());
			void'(exp_y_q.pop_front());
		end else if (done !== 1'b0) begin
			$display("%0t ns: done was high with no result due", $time);
			error_count++;
		end
		if (done === 1'b1) begin
			in_flight--;
		end
		if (start === 1'b1 && rst_n === 1'b1) begin // Sampled at the next rising edge.
			compute_expected(joint_angles, link_lengths, jx, jy);
			due_q.push_back(edge_count + LATENCY);
			exp_x_q.push_back(jx);
			exp_y_q.push_back(jy);
			in_flight++;
		end
		if (in_flight > max_depth) begin
			max_depth = in_flight;
		end
	end

	function automatic angle_vec_t random_angles();
		angle_vec_t v;
		for (int i = 0; i < NUM_LINKS; i++) begin
			v[i] = jacobian_pkg::angle_t'($urandom);
		end
		return v;
	endfunction

	function automatic length_vec_t random_lengths();
		length_vec_t v;
		for (int i = 0; i < NUM_LINKS; i++) begin
			v[i] = jacobian_pkg::length_t'($urandom);
		end
		return v;
	endfunction

	task automatic send(input angle_vec_t angles, input length_vec_t lengths);
		start = 1'b1;
		joint_angles = angles;
		link_lengths = lengths;
		@(posedge clk);
		#1;
	endtask

	task automatic idle(input int cycles);
		start = 1'b0;
		repeat (cycles) begin
			@(posedge clk);
			#1;
		end
	endtask

	task automatic drain();
		start = 1'b0;
		while (due_q.size() != 0) begin
			@(posedge clk);
			#1;
		end
		idle(2);
	endtask

	task automatic report_test(input string name, input int errors_before);
		if (error_count == errors_before) begin
			pass_count++;
			$display("test %s: ok", name);
		end else begin
			fail_count++;
			$display("test %s: FAILED with %0d errors", name, error_count - errors_before);
		end
	endtask

	task automatic reset_and_idle();
		int errors_before;
		errors_before = error_count;
		repeat (2) begin
			@(posedge clk);
			#1;
			if (done !== 1'b0) begin
				$display("[ERROR] %0t ns done expected 0 actual %b", $time, done);
				error_count++;
			end
		end
		rst_n = 1'b1;
		idle(10); // Any done in here has no start behind it.
		report_test("reset and idle", errors_before);
	endtask

	task automatic straight_arm();
		int errors_before;
		int suffix;
		length_vec_t lengths;
		errors_before = error_count;
		lengths = '0;
		for (int k = 0; k < N_ZERO; k++) begin
			lengths = random_lengths();
			send('0, lengths);
		end
		drain();
		// The last result holds, and a straight arm only reaches along x.
		suffix = 0;
		for (int j = NUM_LINKS - 1; j >= 0; j--) begin
			suffix += int'(lengths[j]);
			if (jac_x[j] !== '0) begin
				$display("[ERROR] %0t ns jac_x[%0d] expected 0 actual %0d", $time, j,
					$signed(jac_x[j]));
				error_count++;
			end
			if (jac_y[j] !== jacobian_pkg::jac_t'(127 * suffix)) begin
				$display("[ERROR] %0t ns jac_y[%0d] expected %0d actual %0d", $time, j,
					127 * suffix, $signed(jac_y[j]));
				error_count++;
			end
		end
		report_test("straight arm", errors_before);
	endtask

	task automatic isolated_transactions();
		int errors_before;
		errors_before = error_count;
		for (int k = 0; k < N_ISOLATED; k++) begin
			send(random_angles(), random_lengths());
			idle(LATENCY + int'($urandom % (MAX_GAP - LATENCY + 1)));
		end
		drain();
		report_test("isolated transactions", errors_before);
	endtask

	task automatic back_to_back();
		int errors_before;
		errors_before = error_count;
		max_depth = 0;
		for (int k = 0; k < N_BURST; k++) begin
			send(random_angles(), random_lengths());
		end
		drain();
		if (max_depth < LATENCY) begin
			$display("%0t ns: back-to-back starts never filled the pipeline", $time);
			error_count++;
		end
		report_test("back to back", errors_before);
	endtask

	task automatic quadrant_corners();
		int errors_before;
		angle_vec_t angles;
		length_vec_t lengths;
		errors_before = error_count;
		lengths = {NUM_LINKS{8'd255}}; // Longest links give the widest sums.
		for (int k = 0; k < N_CORNER; k++) begin
			for (int i = 0; i < NUM_LINKS; i++) begin
				angles[i] = (k < 8) ? corners[k] : corners[3'($urandom)];
			end
			send(angles, lengths);
		end
		drain();
		report_test("quadrant corners", errors_before);
	endtask

	initial begin
		rst_n = 1'b0;
		start = 1'b0;
		joint_angles = '0;
		link_lengths = '0;
		void'($urandom(SEED));
		reset_and_idle();
		straight_arm();
		isolated_transactions();
		back_to_back();
		quadrant_corners();
		$display("Summary: %0d of %0d tests ok, %0d failing, %0d errors", pass_count,
			NUM_TESTS, fail_count, error_count);
		if (fail_count == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_CYCLES * 10);
		$display("Watchdog expired after %0d cycles without the run finishing", WATCHDOG_CYCLES);
		$display("tests failed");
		$finish;
	end

endmodule

// ==== tests/planar_jacobian_sva.sv ====
/* Assertions bound into planar_jacobian_top: start-to-done latency,
   quiet reset and known results. */
`timescale 1ns/1ns

module planar_jacobian_sva #(
	parameter int NUM_LINKS = 4
) (
	input logic clk,
	input logic rst_n,
	input logic start,
	input logic done,
	input jacobian_pkg::jac_t [NUM_LINKS-1:0] jac_x,
	input jacobian_pkg::jac_t [NUM_LINKS-1:0] jac_y
);

	localparam int LATENCY = 4;

	// A start taken out of reset comes back as done four edges later.
	a_start_to_done: assert property (@(posedge clk) disable iff (!rst_n)
		$past(start && rst_n, LATENCY) |-> done)
		else $error("done did not follow start after %0d cycles", LATENCY);

	a_done_needs_start: assert property (@(posedge clk) disable iff (!rst_n)
		done |-> $past(start, LATENCY))
		else $error("done rose without a start %0d cycles before", LATENCY);

	// Reset clears done, and nothing can reach it one cycle later either.
	a_quiet_reset: assert property (@(posedge clk)
		($past(!rst_n) || $past(!rst_n, 2)) |-> !done)
		else $error("done was high during or right after reset");

	a_known_results: assert property (@(posedge clk) disable iff (!rst_n)
		done |-> (!$isunknown(jac_x) && !$isunknown(jac_y)))
		else $error("jac_x or jac_y holds unknown bits while done is high");

endmodule

bind planar_jacobian_top planar_jacobian_sva #(
	.NUM_LINKS(NUM_LINKS)
) u_sva (
	.clk(clk),
	.rst_n(rst_n),
	.start(start),
	.done(done),
	.jac_x(jac_x),
	.jac_y(jac_y)
);

// ==== logic/planar_jacobian_top.sv ====
/* Jacobian of a planar serial arm with NUM_LINKS revolute joints.
   Pulse start with angles and lengths; done and the columns follow 4 cycles later. */
`timescale 1ns/1ns

module planar_jacobian_top #(
	parameter int NUM_LINKS = 4
) (
	input logic clk,
	input logic rst_n,
	input logic start, // A new start may come every cycle.
	input jacobian_pkg::angle_t [NUM_LINKS-1:0] joint_angles,
	input jacobian_pkg::length_t [NUM_LINKS-1:0] link_lengths,
	output logic done,
	output jacobian_pkg::jac_t [NUM_LINKS-1:0] jac_x,
	output jacobian_pkg::jac_t [NUM_LINKS-1:0] jac_y
);

	// One bundle per link, from the feeder through the link_term to the drain.
	link_term_if links [NUM_LINKS-1:0] ();

	angle_accumulator #(
		.NUM_LINKS(NUM_LINKS)
	) u_accumulator (
		.clk(clk),
		.rst_n(rst_n),
		.start(start),
		.joint_angles(joint_angles),
		.link_lengths(link_lengths),
		.links(links)
	);

	// Identical trig and multiply stage for every link.
	for (genvar g = 0; g < NUM_LINKS; g++) begin : g_link
		link_term u_link_term (
			.clk(clk),
			.rst_n(rst_n),
			.link(links[g])
		);
	end

	jacobian_assembler #(
		.NUM_LINKS(NUM_LINKS)
	) u_assembler (
		.clk(clk),
		.rst_n(rst_n),
		.links(links),
		.done(done),
		.jac_x(jac_x),
		.jac_y(jac_y)
	);

endmodule

// ==== logic/jacobian_assembler.sv ====
/* Last pipeline stage: adds the link contributions from the tip back to each
   joint and registers the Jacobian columns together with done. */
`timescale 1ns/1ns

module jacobian_assembler #(
	parameter int NUM_LINKS = 4
) (
	input logic clk,
	input logic rst_n,
	link_term_if.drain links [NUM_LINKS-1:0],
	output logic done,
	output jacobian_pkg::jac_t [NUM_LINKS-1:0] jac_x,
	output jacobian_pkg::jac_t [NUM_LINKS-1:0] jac_y
);

	jacobian_pkg::term_t x_in [NUM_LINKS];
	jacobian_pkg::term_t y_in [NUM_LINKS];
	jacobian_pkg::jac_t sum_x [NUM_LINKS]; // Sum of x terms from link i to the tip.
	jacobian_pkg::jac_t sum_y [NUM_LINKS];
	logic load;

	// All links run in lockstep, so link 0 qualifies the whole set.
	assign load = links[0].term_valid;

	// Interface array elements need constant indices, so copy them out first.
	for (genvar g = 0; g < NUM_LINKS; g++) begin : g_drain
		assign x_in[g] = links[g].x_term;
		assign y_in[g] = links[g].y_term;
	end

	// Joint j moves every link from j outward, so its column sums that suffix.
	always_comb begin
		sum_x[NUM_LINKS-1] = jacobian_pkg::jac_t'(x_in[NUM_LINKS-1]);
		sum_y[NUM_LINKS-1] = jacobian_pkg::jac_t'(y_in[NUM_LINKS-1]);
		for (int i = NUM_LINKS - 2; i >= 0; i--) begin
			sum_x[i] = sum_x[i+1] + jacobian_pkg::jac_t'(x_in[i]);
			sum_y[i] = sum_y[i+1] + jacobian_pkg::jac_t'(y_in[i]);
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			done <= 1'b0;
			jac_x <= '0;
			jac_y <= '0;
		end else begin
			done <= load;
			if (load) begin // Results hold until the next set arrives.
				for (int i = 0; i < NUM_LINKS; i++) begin
					jac_x[i] <= -sum_y[i]; // dx/dtheta is minus the y lever.
					jac_y[i] <= sum_x[i];
				end
			end
		end
	end

endmodule

// ==== logic/link_term.sv ====
/* Two-stage link contribution: a registered sine and cosine lookup, then a
   registered multiply by the link length. One instance per link. */
`timescale 1ns/1ns

module link_term (
	input logic clk,
	input logic rst_n,
	link_term_if.unit link
);

	`include "sine_table.svh"

	jacobian_pkg::angle_t cos_angle; // Cosine is the sine a quarter turn ahead.
	logic lookup_valid;
	jacobian_pkg::trig_t sin_r;
	jacobian_pkg::trig_t cos_r;
	jacobian_pkg::length_t length_r;

	// Maps any angle onto the quarter table and restores the sign of the half turn.
	function automatic jacobian_pkg::trig_t fold_sine(input jacobian_pkg::angle_t a);
		logic [6:0] index;
		jacobian_pkg::trig_t mag;
		index = a[6] ? 7'd64 - {1'b0, a[5:0]} : {1'b0, a[5:0]};
		mag = sine_quarter(index);
		return a[7] ? -mag : mag;
	endfunction

	// Signed product of an unsigned length and a trig sample.
	function automatic jacobian_pkg::term_t scale(
		input jacobian_pkg::length_t len,
		input jacobian_pkg::trig_t s
	);
		jacobian_pkg::term_t wide_len;
		jacobian_pkg::term_t wide_s;
		wide_len = jacobian_pkg::term_t'({1'b0, len});
		wide_s = jacobian_pkg::term_t'(s);
		return wide_len * wide_s; // At most 255 * 127, so 16 bits hold it.
	endfunction

	assign cos_angle = link.angle + jacobian_pkg::angle_t'(64);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			lookup_valid <= 1'b0;
			sin_r <= '0;
			cos_r <= '0;
			length_r <= '0;
			link.term_valid <= 1'b0;
			link.x_term <= '0;
			link.y_term <= '0;
		end else begin
			lookup_valid <= link.valid; // Table lookup stage.
			sin_r <= fold_sine(link.angle);
			cos_r <= fold_sine(cos_angle);
			length_r <= link.length;
			link.term_valid <= lookup_valid; // Multiply stage.
			link.x_term <= scale(length_r, cos_r);
			link.y_term <= scale(length_r, sin_r);
		end
	end

endmodule

// ==== logic/angle_accumulator.sv ====
/* First pipeline stage: turns relative joint angles into absolute link angles
   and registers them, with the link lengths, into every link's bundle. */
`timescale 1ns/1ns

module angle_accumulator #(
	parameter int NUM_LINKS = 4
) (
	input logic clk,
	input logic rst_n,
	input logic start,
	input jacobian_pkg::angle_t [NUM_LINKS-1:0] joint_angles,
	input jacobian_pkg::length_t [NUM_LINKS-1:0] link_lengths,
	link_term_if.feed links [NUM_LINKS-1:0]
);

	// Absolute angle of each link, before the register.
	jacobian_pkg::angle_t phi [NUM_LINKS];

	// Running sum from the base joint outward. The 8-bit sum wraps at a full turn.
	always_comb begin
		phi[0] = joint_angles[0];
		for (int i = 1; i < NUM_LINKS; i++) begin
			phi[i] = phi[i-1] + joint_angles[i];
		end
	end

	// Each link's bundle is a separate instance, so each gets its own register block.
	for (genvar g = 0; g < NUM_LINKS; g++) begin : g_feed
		always_ff @(posedge clk) begin
			if (!rst_n) begin
				links[g].valid <= 1'b0;
				links[g].angle <= '0;
				links[g].length <= '0;
			end else begin
				links[g].valid <= start; // Every link sees the same strobe.
				links[g].angle <= phi[g];
				links[g].length <= link_lengths[g];
			end
		end
	end

endmodule

// ==== logic/link_term_if.sv ====
/* Per-link bundle: the feeder hands each link_term its angle and length,
   and the link_term hands its x and y contributions on to the assembler. */
`timescale 1ns/1ns

interface link_term_if;

	logic valid; // Qualifies angle and length for one cycle.
	jacobian_pkg::angle_t angle; // Absolute link angle.
	jacobian_pkg::length_t length;

	logic term_valid; // Qualifies both terms for one cycle.
	jacobian_pkg::term_t x_term;
	jacobian_pkg::term_t y_term;

	// Angle accumulator side.
	modport feed (output valid, output angle, output length);

	// The link_term itself.
	modport unit (
		input valid,
		input angle,
		input length,
		output term_valid,
		output x_term,
		output y_term
	);

	// Jacobian assembler side.
	modport drain (input term_valid, input x_term, input y_term);

endinterface

// ==== logic/jacobian_pkg.sv ====
/* Widths and vector types shared by the planar arm Jacobian datapath.
   Referenced by scoped names from every design file. */
package jacobian_pkg;

	// An angle of 2**ANGLE_W steps makes one full turn.
	localparam int ANGLE_W = 8;
	localparam int LENGTH_W = 8;
	localparam int TRIG_W = 8;
	localparam int TERM_W = 16;
	localparam int JAC_W = 20; // Room for the sum of 16 terms.

	// Absolute or relative angle; arithmetic wraps at a full turn.
	typedef logic [ANGLE_W-1:0] angle_t;

	// Unsigned link length.
	typedef logic [LENGTH_W-1:0] length_t;

	// Sine or cosine sample scaled by 127.
	typedef logic signed [TRIG_W-1:0] trig_t;

	// Length times a trig sample.
	typedef logic signed [TERM_W-1:0] term_t;

	// One Jacobian entry.
	typedef logic signed [JAC_W-1:0] jac_t;

endpackage

// ==== include/sine_table.svh ====
/* Quarter-wave sine samples scaled by 127, for indices 0 to 64 of a 256-step turn.
   Included inside a module body; callers fold the angle onto the first quadrant. */
`ifndef SINE_TABLE_SVH
`define SINE_TABLE_SVH

// Returns round(127 * sin(2*pi*index/256)) for index 0 to 64.
function automatic jacobian_pkg::trig_t sine_quarter(input logic [6:0] index);
	jacobian_pkg::trig_t sample;
	case (index)
		7'd0: sample = 8'sd0;
		7'd1: sample = 8'sd3;
		7'd2: sample = 8'sd6;
		7'd3: sample = 8'sd9;
		7'd4: sample = 8'sd12;
		7'd5: sample = 8'sd16;
		7'd6: sample = 8'sd19;
		7'd7: sample = 8'sd22;
		7'd8: sample = 8'sd25;
		7'd9: sample = 8'sd28;
		7'd10: sample = 8'sd31;
		7'd11: sample = 8'sd34;
		7'd12: sample = 8'sd37;
		7'd13: sample = 8'sd40;
		7'd14: sample = 8'sd43;
		7'd15: sample = 8'sd46;
		7'd16: sample = 8'sd49; // 22.5 degrees.
		7'd17: sample = 8'sd51;
		7'd18: sample = 8'sd54;
		7'd19: sample = 8'sd57;
		7'd20: sample = 8'sd60;
		7'd21: sample = 8'sd63;
		7'd22: sample = 8'sd65;
		7'd23: sample = 8'sd68;
		7'd24: sample = 8'sd71;
		7'd25: sample = 8'sd73;
		7'd26: sample = 8'sd76;
		7'd27: sample = 8'sd78;
		7'd28: sample = 8'sd81;
		7'd29: sample = 8'sd83;
		7'd30: sample = 8'sd85;
		7'd31: sample = 8'sd88;
		7'd32: sample = 8'sd90; // 45 degrees.
		7'd33: sample = 8'sd92;
		7'd34: sample = 8'sd94;
		7'd35: sample = 8'sd96;
		7'd36: sample = 8'sd98;
		7'd37: sample = 8'sd100;
		7'd38: sample = 8'sd102;
		7'd39: sample = 8'sd104;
		7'd40: sample = 8'sd106;
		7'd41: sample = 8'sd107;
		7'd42: sample = 8'sd109;
		7'd43: sample = 8'sd111; // 110.501 before rounding.
		7'd44: sample = 8'sd112;
		7'd45: sample = 8'sd113;
		7'd46: sample = 8'sd115;
		7'd47: sample = 8'sd116;
		7'd48: sample = 8'sd117;
		7'd49: sample = 8'sd118;
		7'd50: sample = 8'sd120;
		7'd51: sample = 8'sd121;
		7'd52: sample = 8'sd122;
		7'd53: sample = 8'sd122;
		7'd54: sample = 8'sd123;
		7'd55: sample = 8'sd124;
		7'd56: sample = 8'sd125;
		7'd57: sample = 8'sd125;
		7'd58: sample = 8'sd126;
		7'd59: sample = 8'sd126;
		7'd60: sample = 8'sd126;
		7'd61: sample = 8'sd127;
		7'd62: sample = 8'sd127;
		7'd63: sample = 8'sd127;
		7'd64: sample = 8'sd127; // Quarter turn.
		default: sample = 8'sd0; // Folding never produces these indices.
	endcase
	return sample;
endfunction

`endif
